/* hdl/br_alu.sv */
`timescale 1ns/100ps

module br_alu (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  fu_pkg::issue_pkt_t pkt_i,
	output fu_pkg::unit_res_t  res_o
);

	fu_pkg::word_t     npc;
	fu_pkg::word_t     disp;
	logic              taken;
	fu_pkg::unit_res_t res_r;

	assign npc  = pkt_i.pc + 64'd4;
	// Word displacement, sign extended
	assign disp = {{41{pkt_i.inst[20]}}, pkt_i.inst[20:0], 2'b00};

	always_comb begin
		case (pkt_i.inst[31:26])
			fu_pkg::OP_BR:  taken = 1'b1;
			fu_pkg::OP_BEQ: taken = pkt_i.opa == '0;
			fu_pkg::OP_BNE: taken = pkt_i.opa != '0;
			fu_pkg::OP_BLT: taken = pkt_i.opa[63];
			fu_pkg::OP_BGE: taken = !pkt_i.opa[63];
			default:        taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			res_r.rob_idx   <= pkt_i.rob_idx;
			res_r.wr_en     <= 1'b0;
			res_r.dest_tag  <= pkt_i.dest_tag;
			res_r.value     <= npc;
			res_r.br_taken  <= taken;
			res_r.br_target <= npc + disp;
		end
		if (rst)
			res_r.valid <= 1'b0;
		else
			res_r.valid <= start_i;
	end

	assign res_o = res_r;

endmodule

/* hdl/fu_complete.sv */
`timescale 1ns/100ps

module fu_complete (
	input  logic              clk,
	input  logic              rst,
	input  fu_pkg::unit_res_t int_res_i,
	input  fu_pkg::unit_res_t br_res_i,
	input  fu_pkg::unit_res_t mult_res_i,
	output logic              mult_grant_o,
	output fu_pkg::unit_res_t complete_o,
	output fu_pkg::cdb_tag_t  cdb_tag_o
);

	fu_pkg::cdb_tag_t cdb_r;

	// ------------------------------------------------------------
	// Single-cycle units first, multiplier takes the free slots
	// ------------------------------------------------------------
	always_comb begin
		mult_grant_o = 1'b0;
		if (int_res_i.valid) begin
			complete_o = int_res_i;
		end else if (br_res_i.valid) begin
			complete_o = br_res_i;
		end else begin
			complete_o   = mult_res_i;
			mult_grant_o = mult_res_i.valid;
		end
	end

	// ------------------------------------------------------------
	// Tag broadcast, one cycle after the write
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		cdb_r.tag <= complete_o.dest_tag;
		if (rst)
			cdb_r.valid <= 1'b0;
		else
			cdb_r.valid <= complete_o.valid && complete_o.wr_en;
	end

	assign cdb_tag_o = cdb_r;

	// Both single-cycle units share one issue slot
	a_one_fast: assert property (@(posedge clk) disable iff (rst)
		!(int_res_i.valid && br_res_i.valid))
		else $error("integer and branch results collide");

endmodule

/* hdl/fu_main.sv */
`timescale 1ns/100ps

module fu_main (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue_valid_i,
	input  fu_pkg::fu_sel_e    issue_sel_i,
	input  fu_pkg::issue_pkt_t issue_pkt_i,
	output logic               mult_ready_o,
	output fu_pkg::unit_res_t  complete_o,
	output fu_pkg::cdb_tag_t   cdb_tag_o
);

	logic int_start;
	logic br_start;
	logic mult_start;

	logic mult_load;
	logic mult_step;
	logic mult_done;
	logic mult_grant;

	fu_pkg::unit_res_t int_res;
	fu_pkg::unit_res_t br_res;
	fu_pkg::unit_res_t mult_res;

	// Unit steering
	assign int_start  = issue_valid_i && issue_sel_i == fu_pkg::FU_INT;
	assign br_start   = issue_valid_i && issue_sel_i == fu_pkg::FU_BR;
	assign mult_start = issue_valid_i && issue_sel_i == fu_pkg::FU_MULT;

	// ------------------------------------------------------------
	// Single-cycle units
	// ------------------------------------------------------------
	int_alu int_alu_inst (
		.clk     (clk),
		.rst     (rst),
		.start_i (int_start),
		.pkt_i   (issue_pkt_i),
		.res_o   (int_res)
	);

	br_alu br_alu_inst (
		.clk     (clk),
		.rst     (rst),
		.start_i (br_start),
		.pkt_i   (issue_pkt_i),
		.res_o   (br_res)
	);

	// ------------------------------------------------------------
	// Iterative multiplier
	// ------------------------------------------------------------
	mult_ctrl mult_ctrl_inst (
		.clk     (clk),
		.rst     (rst),
		.start_i (mult_start),
		.grant_i (mult_grant),
		.ready_o (mult_ready_o),
		.step_o  (mult_step),
		.load_o  (mult_load),
		.done_o  (mult_done)
	);

	mult_datapath mult_datapath_inst (
		.clk    (clk),
		.load_i (mult_load),
		.step_i (mult_step),
		.done_i (mult_done),
		.pkt_i  (issue_pkt_i),
		.res_o  (mult_res)
	);

	fu_complete fu_complete_inst (
		.clk          (clk),
		.rst          (rst),
		.int_res_i    (int_res),
		.br_res_i     (br_res),
		.mult_res_i   (mult_res),
		.mult_grant_o (mult_grant),
		.complete_o   (complete_o),
		.cdb_tag_o    (cdb_tag_o)
	);

endmodule

/* hdl/fu_pkg.sv */
package fu_pkg;

	// ------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------
	typedef logic [63:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [5:0]  prf_idx_t;
	typedef logic [4:0]  rob_idx_t;

	localparam int MULT_STEPS     = 16;
	localparam int MULT_STEP_BITS = 4;

	// Opcodes in inst[31:26]
	localparam logic [5:0] OP_INTA = 6'h10;
	localparam logic [5:0] OP_INTL = 6'h11;
	localparam logic [5:0] OP_INTS = 6'h12;
	localparam logic [5:0] OP_MUL  = 6'h13;
	localparam logic [5:0] OP_BR   = 6'h30;
	localparam logic [5:0] OP_BEQ  = 6'h39;
	localparam logic [5:0] OP_BNE  = 6'h3d;
	localparam logic [5:0] OP_BLT  = 6'h3a;
	localparam logic [5:0] OP_BGE  = 6'h3e;

	// Function codes in inst[11:5]
	localparam logic [6:0] FN_ADD    = 7'h20;
	localparam logic [6:0] FN_SUB    = 7'h29;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPLT  = 7'h4d;
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_AND    = 7'h00;
	localparam logic [6:0] FN_OR     = 7'h08;
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRL    = 7'h34;

	typedef enum logic [1:0] {FU_INT, FU_BR, FU_MULT} fu_sel_e;

	typedef enum logic [1:0] {MS_IDLE, MS_BUSY, MS_DONE} mult_state_e;

	// ------------------------------------------------------------
	// Bundles
	// ------------------------------------------------------------
	typedef struct packed {
		word_t    pc;
		word_t    opa;
		word_t    opb;
		inst_t    inst;
		prf_idx_t dest_tag;
		rob_idx_t rob_idx;
	} issue_pkt_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
		logic     wr_en;
		prf_idx_t dest_tag;
		word_t    value;
		logic     br_taken;
		word_t    br_target;
	} unit_res_t;

	typedef struct packed {
		logic     valid;
		prf_idx_t tag;
	} cdb_tag_t;

	// Operand B is the zero-extended 8-bit literal when inst[12] is set
	function automatic word_t operand_b(issue_pkt_t pkt);
		word_t lit;
		lit = {56'b0, pkt.inst[20:13]};
		return pkt.inst[12] ? lit : pkt.opb;
	endfunction

endpackage

/* hdl/int_alu.sv */
`timescale 1ns/100ps

module int_alu (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  fu_pkg::issue_pkt_t pkt_i,
	output fu_pkg::unit_res_t  res_o
);

	fu_pkg::word_t     opa;
	fu_pkg::word_t     opb;
	fu_pkg::word_t     result;
	logic [6:0]        fn;
	logic [5:0]        opcode;
	logic              fn_known;
	fu_pkg::unit_res_t res_r;

	assign opa    = pkt_i.opa;
	assign opb    = fu_pkg::operand_b(pkt_i);
	assign fn     = pkt_i.inst[11:5];
	assign opcode = pkt_i.inst[31:26];

	always_comb begin
		fn_known = 1'b1;
		case (fn)
			fu_pkg::FN_ADD:    result = opa + opb;
			fu_pkg::FN_SUB:    result = opa - opb;
			fu_pkg::FN_CMPEQ:  result = {63'b0, opa == opb};
			fu_pkg::FN_CMPLT:  result = {63'b0, $signed(opa) < $signed(opb)};
			fu_pkg::FN_CMPULT: result = {63'b0, opa < opb};
			fu_pkg::FN_AND:    result = opa & opb;
			fu_pkg::FN_OR:     result = opa | opb;
			fu_pkg::FN_XOR:    result = opa ^ opb;
			fu_pkg::FN_SLL:    result = opa << opb[5:0];
			fu_pkg::FN_SRL:    result = opa >> opb[5:0];
			default: begin
				result   = '0;
				fn_known = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			res_r.rob_idx   <= pkt_i.rob_idx;
			res_r.wr_en     <= 1'b1;
			res_r.dest_tag  <= pkt_i.dest_tag;
			res_r.value     <= result;
			res_r.br_taken  <= 1'b0;
			res_r.br_target <= '0;
		end
		// One completion per start
		if (rst)
			res_r.valid <= 1'b0;
		else
			res_r.valid <= start_i;
	end

	assign res_o = res_r;

	// The issue side only sends operate-format integer instructions here
	a_known_op: assert property (@(posedge clk) disable iff (rst)
		start_i |-> fn_known && (opcode == fu_pkg::OP_INTA ||
			opcode == fu_pkg::OP_INTL || opcode == fu_pkg::OP_INTS))
		else $error("int_alu started with unknown opcode %h fn %h", opcode, fn);

endmodule

/* hdl/mult_ctrl.sv */
`timescale 1ns/100ps

module mult_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  logic grant_i,
	output logic ready_o,
	output logic step_o,
	output logic load_o,
	output logic done_o
);

	fu_pkg::mult_state_e state;
	fu_pkg::mult_state_e state_nxt;
	logic [$clog2(fu_pkg::MULT_STEPS)-1:0] step_cnt;
	logic last_step;

	// The load cycle forms the first partial product, so BUSY runs one step short
	assign last_step = int'(step_cnt) == fu_pkg::MULT_STEPS - 2;

	assign ready_o = state == fu_pkg::MS_IDLE;
	assign load_o  = start_i && state == fu_pkg::MS_IDLE;
	assign step_o  = state == fu_pkg::MS_BUSY;
	assign done_o  = state == fu_pkg::MS_DONE;

	always_comb begin
		state_nxt = state;
		case (state)
			fu_pkg::MS_IDLE: if (start_i) state_nxt = fu_pkg::MS_BUSY;
			fu_pkg::MS_BUSY: if (last_step) state_nxt = fu_pkg::MS_DONE;
			// Hold the result until the completion port takes it
			fu_pkg::MS_DONE: if (grant_i) state_nxt = fu_pkg::MS_IDLE;
			default:         state_nxt = fu_pkg::MS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= fu_pkg::MS_IDLE;
			step_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (load_o)
				step_cnt <= '0;
			else if (step_o)
				step_cnt <= step_cnt + 1'b1;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		start_i |-> state == fu_pkg::MS_IDLE)
		else $error("multiply issued while multiplier busy");

	a_grant_done: assert property (@(posedge clk) disable iff (rst)
		grant_i |-> state == fu_pkg::MS_DONE)
		else $error("multiplier granted outside MS_DONE");

endmodule

/* hdl/mult_datapath.sv */
`timescale 1ns/100ps

module mult_datapath (
	input  logic               clk,
	input  logic               load_i,
	input  logic               step_i,
	input  logic               done_i,
	input  fu_pkg::issue_pkt_t pkt_i,
	output fu_pkg::unit_res_t  res_o
);

	fu_pkg::word_t    acc_r;
	fu_pkg::word_t    mcand_r;
	fu_pkg::word_t    mplier_r;
	fu_pkg::prf_idx_t tag_r;
	fu_pkg::rob_idx_t rob_r;

	fu_pkg::word_t acc_src;
	fu_pkg::word_t mcand_src;
	fu_pkg::word_t mplier_src;
	fu_pkg::word_t partial;

	// On load, the first step works straight from the issued operands
	assign acc_src    = load_i ? '0 : acc_r;
	assign mcand_src  = load_i ? pkt_i.opa : mcand_r;
	assign mplier_src = load_i ? fu_pkg::operand_b(pkt_i) : mplier_r;

	assign partial = mcand_src *
		fu_pkg::word_t'(mplier_src[fu_pkg::MULT_STEP_BITS-1:0]);

	always_ff @(posedge clk) begin
		if (load_i || step_i) begin
			acc_r    <= acc_src + partial;
			mcand_r  <= mcand_src << fu_pkg::MULT_STEP_BITS;
			mplier_r <= mplier_src >> fu_pkg::MULT_STEP_BITS;
		end
		if (load_i) begin
			tag_r <= pkt_i.dest_tag;
			rob_r <= pkt_i.rob_idx;
		end
	end

	always_comb begin
		res_o.valid     = done_i;
		res_o.rob_idx   = rob_r;
		res_o.wr_en     = 1'b1;
		res_o.dest_tag  = tag_r;
		res_o.value     = acc_r;
		res_o.br_taken  = 1'b0;
		res_o.br_target = '0;
	end

	// Only multiplies are steered to this unit
	a_mul_op: assert property (@(posedge clk)
		load_i |-> pkt_i.inst[31:26] == fu_pkg::OP_MUL)
		else $error("multiplier loaded with opcode %h", pkt_i.inst[31:26]);

endmodule

/* project.f */
hdl/fu_pkg.sv
hdl/int_alu.sv
hdl/br_alu.sv
hdl/mult_ctrl.sv
hdl/mult_datapath.sv
hdl/fu_complete.sv
hdl/fu_main.sv
testbench/fu_main_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fu_main testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	-f project.f --top-module fu_main_tb -Mdir "$BUILD_DIR" -o fu_main_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/fu_main_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "TESTS FAILED" "$LOG_FILE"; then
	echo "Simulation failed"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
echo "Simulation passed"
exit 0

/* testbench/fu_main_tb.sv */
`timescale 1ns/100ps

module fu_main_tb;

	localparam int TIMEOUT_CYCLES = 40;

	logic               clk;
	logic               rst;
	logic               issue_valid;
	fu_pkg::fu_sel_e    issue_sel;
	fu_pkg::issue_pkt_t issue_pkt;
	logic               mult_ready;
	fu_pkg::unit_res_t  complete;
	fu_pkg::cdb_tag_t   cdb_tag;
	logic [31:0]        lcg_state;
	logic [4:0]         rob_cnt;
	logic [5:0]         tag_cnt;

	fu_main fu_main_inst (
		.clk           (clk),
		.rst           (rst),
		.issue_valid_i (issue_valid),
		.issue_sel_i   (issue_sel),
		.issue_pkt_i   (issue_pkt),
		.mult_ready_o  (mult_ready),
		.complete_o    (complete),
		.cdb_tag_o     (cdb_tag)
	);

	always #20 clk = ~clk;

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [63:0] rand_word();
		logic [31:0] hi;
		hi = lcg_next();
		return {hi, lcg_next()};
	endfunction

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// Counts the cycles spent waiting; with busy set the multiplier must stay not ready
	task automatic wait_complete(input string name, input logic busy, output int waited);
		waited = 0;
		while (!complete.valid) begin
			if (busy)
				check_value({name, " ready"}, 64'd0, 64'(mult_ready));
			if (waited >= TIMEOUT_CYCLES) begin
				$display("Timeout: no completion arrived for %s", name);
				abort_run();
			end else begin
				next_cycle();
				waited++;
			end
		end
	endtask

	function automatic fu_pkg::issue_pkt_t make_pkt(logic [63:0] pc, logic [63:0] a,
			logic [63:0] b, logic [31:0] inst);
		fu_pkg::issue_pkt_t pkt;
		pkt.pc       = pc;
		pkt.opa      = a;
		pkt.opb      = b;
		pkt.inst     = inst;
		pkt.dest_tag = tag_cnt;
		pkt.rob_idx  = rob_cnt;
		tag_cnt      = tag_cnt + 6'd5;
		rob_cnt      = rob_cnt + 5'd1;
		return pkt;
	endfunction

	task automatic issue_instr(input fu_pkg::fu_sel_e sel, input fu_pkg::issue_pkt_t pkt);
		issue_valid = 1'b1;
		issue_sel   = sel;
		issue_pkt   = pkt;
		next_cycle();
		issue_valid = 1'b0;
	endtask

	task automatic check_written(input string name, input fu_pkg::issue_pkt_t pkt,
			input logic [63:0] value);
		check_value({name, " value"}, value, complete.value);
		check_value({name, " rob"}, 64'(pkt.rob_idx), 64'(complete.rob_idx));
		check_value({name, " tag"}, 64'(pkt.dest_tag), 64'(complete.dest_tag));
		check_value({name, " wr_en"}, 64'd1, 64'(complete.wr_en));
	endtask

	task automatic check_broadcast(input string name, input fu_pkg::issue_pkt_t pkt,
			input logic written);
		next_cycle();
		check_value({name, " cdb valid"}, 64'(written), 64'(cdb_tag.valid));
		if (written)
			check_value({name, " cdb tag"}, 64'(pkt.dest_tag), 64'(cdb_tag.tag));
	endtask

	// ------------------------------------------------------------
	// Reference models
	// ------------------------------------------------------------
	function automatic logic [63:0] int_model(logic [6:0] fn, logic [63:0] a, logic [63:0] b);
		case (fn)
			fu_pkg::FN_ADD:    return a + b;
			fu_pkg::FN_SUB:    return a - b;
			fu_pkg::FN_CMPEQ:  return 64'(a == b);
			fu_pkg::FN_CMPLT:  return 64'($signed(a) < $signed(b));
			fu_pkg::FN_CMPULT: return 64'(a < b);
			fu_pkg::FN_AND:    return a & b;
			fu_pkg::FN_OR:     return a | b;
			fu_pkg::FN_XOR:    return a ^ b;
			fu_pkg::FN_SLL:    return a << b[5:0];
			fu_pkg::FN_SRL:    return a >> b[5:0];
			default:           return 64'd0;
		endcase
	endfunction

	function automatic logic branch_model(logic [5:0] op, logic [63:0] a);
		case (op)
			fu_pkg::OP_BR:  return 1'b1;
			fu_pkg::OP_BEQ: return a == 64'd0;
			fu_pkg::OP_BNE: return a != 64'd0;
			fu_pkg::OP_BLT: return $signed(a) < 0;
			fu_pkg::OP_BGE: return $signed(a) >= 0;
			default:        return 1'b0;
		endcase
	endfunction

	function automatic logic [5:0] int_opcode(logic [6:0] fn);
		if (fn == fu_pkg::FN_AND || fn == fu_pkg::FN_OR || fn == fu_pkg::FN_XOR)
			return fu_pkg::OP_INTL;
		if (fn == fu_pkg::FN_SLL || fn == fu_pkg::FN_SRL)
			return fu_pkg::OP_INTS;
		return fu_pkg::OP_INTA;
	endfunction

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------
	task automatic test_reset();
		check_value("reset complete valid", 64'd0, 64'(complete.valid));
		check_value("reset cdb valid", 64'd0, 64'(cdb_tag.valid));
		check_value("reset mult ready", 64'd1, 64'(mult_ready));
	endtask

	task automatic run_int(input logic [6:0] fn, input logic [63:0] a, input logic [63:0] b,
			input logic use_lit, input logic [7:0] lit);
		fu_pkg::issue_pkt_t pkt;
		logic [63:0]        b_eff;
		int                 waited;
		string              name;
		name  = $sformatf("int fn %h lit %0d", fn, use_lit);
		b_eff = use_lit ? {56'd0, lit} : b;
		pkt   = make_pkt(rand_word(), a, b, {int_opcode(fn), 5'd1, lit, use_lit, fn, 5'd2});
		issue_instr(fu_pkg::FU_INT, pkt);
		wait_complete(name, 1'b0, waited);
		check_value({name, " latency"}, 64'd1, 64'(waited + 1));
		check_written(name, pkt, int_model(fn, a, b_eff));
		check_broadcast(name, pkt, 1'b1);
		check_value({name, " single"}, 64'd0, 64'(complete.valid));
	endtask

	task automatic test_int_ops();
		logic [6:0]  fns [10];
		logic [63:0] a;
		logic [31:0] r;
		fns = '{fu_pkg::FN_ADD, fu_pkg::FN_SUB, fu_pkg::FN_CMPEQ, fu_pkg::FN_CMPLT,
			fu_pkg::FN_CMPULT, fu_pkg::FN_AND, fu_pkg::FN_OR, fu_pkg::FN_XOR,
			fu_pkg::FN_SLL, fu_pkg::FN_SRL};
		for (int i = 0; i < 10; i++) begin
			for (int l = 0; l < 2; l++) begin
				r = lcg_next();
				run_int(fns[i], rand_word(), rand_word(), l[0], r[7:0]);
			end
		end
		// Equal operands for the compares
		a = rand_word();
		run_int(fu_pkg::FN_CMPEQ, a, a, 1'b0, 8'd0);
		run_int(fu_pkg::FN_CMPEQ, 64'h5a, 64'd0, 1'b1, 8'h5a);
		run_int(fu_pkg::FN_CMPULT, a, a, 1'b0, 8'd0);
	endtask

	task automatic run_branch(input logic [5:0] op, input logic [63:0] a);
		fu_pkg::issue_pkt_t pkt;
		logic [63:0]        pc;
		logic [63:0]        disp;
		logic [31:0]        r;
		int                 waited;
		string              name;
		name = $sformatf("branch op %h opa %h", op, a);
		pc   = rand_word() & ~64'd3;
		r    = lcg_next();
		disp = {{43{r[20]}}, r[20:0]};
		pkt  = make_pkt(pc, a, rand_word(), {op, 5'd3, r[20:0]});
		issue_instr(fu_pkg::FU_BR, pkt);
		wait_complete(name, 1'b0, waited);
		check_value({name, " latency"}, 64'd1, 64'(waited + 1));
		check_value({name, " taken"}, 64'(branch_model(op, a)), 64'(complete.br_taken));
		check_value({name, " target"}, pc + 64'd4 + disp * 64'd4, complete.br_target);
		check_value({name, " wr_en"}, 64'd0, 64'(complete.wr_en));
		check_value({name, " rob"}, 64'(pkt.rob_idx), 64'(complete.rob_idx));
		check_broadcast(name, pkt, 1'b0);
		check_value({name, " single"}, 64'd0, 64'(complete.valid));
	endtask

	task automatic test_branches();
		logic [5:0]  ops [5];
		logic [63:0] opas [3];
		logic [63:0] w;
		ops = '{fu_pkg::OP_BR, fu_pkg::OP_BEQ, fu_pkg::OP_BNE, fu_pkg::OP_BLT, fu_pkg::OP_BGE};
		for (int i = 0; i < 5; i++) begin
			w       = rand_word();
			opas[0] = {1'b0, w[62:1], 1'b1};
			opas[1] = 64'd0;
			opas[2] = {1'b1, w[62:0]};
			for (int j = 0; j < 3; j++)
				run_branch(ops[i], opas[j]);
		end
	endtask

	task automatic run_mul(input logic [63:0] a, input logic [63:0] b);
		fu_pkg::issue_pkt_t pkt;
		int                 waited;
		string              name;
		name = $sformatf("mul %h x %h", a, b);
		check_value({name, " ready before"}, 64'd1, 64'(mult_ready));
		pkt = make_pkt(rand_word(), a, b, {fu_pkg::OP_MUL, 5'd4, 8'd0, 1'b0, 7'd0, 5'd5});
		issue_instr(fu_pkg::FU_MULT, pkt);
		wait_complete(name, 1'b1, waited);
		check_value({name, " latency"}, 64'd16, 64'(waited + 1));
		check_value({name, " ready at done"}, 64'd0, 64'(mult_ready));
		check_written(name, pkt, a * b);
		check_broadcast(name, pkt, 1'b1);
		check_value({name, " ready after"}, 64'd1, 64'(mult_ready));
		check_value({name, " single"}, 64'd0, 64'(complete.valid));
	endtask

	task automatic test_multiply();
		for (int i = 0; i < 4; i++)
			run_mul(rand_word(), rand_word());
		run_mul({64{1'b1}}, 64'd7);
	endtask

	// Integer op issued 15 cycles after a multiply lands in the same cycle
	task automatic test_collision();
		fu_pkg::issue_pkt_t mul_pkt;
		fu_pkg::issue_pkt_t int_pkt;
		logic [63:0]        a;
		logic [63:0]        b;
		int                 waited;
		a       = rand_word();
		b       = rand_word();
		mul_pkt = make_pkt(rand_word(), a, b, {fu_pkg::OP_MUL, 26'd0});
		issue_instr(fu_pkg::FU_MULT, mul_pkt);
		repeat (14) next_cycle();
		int_pkt = make_pkt(rand_word(), b, a,
			{fu_pkg::OP_INTA, 5'd0, 8'd0, 1'b0, fu_pkg::FN_ADD, 5'd0});
		issue_instr(fu_pkg::FU_INT, int_pkt);
		wait_complete("collision int", 1'b0, waited);
		check_value("collision int wait", 64'd0, 64'(waited));
		check_written("collision int", int_pkt, a + b);
		check_value("collision ready held", 64'd0, 64'(mult_ready));
		check_broadcast("collision int", int_pkt, 1'b1);
		wait_complete("collision mul", 1'b0, waited);
		check_value("collision mul wait", 64'd0, 64'(waited));
		check_written("collision mul", mul_pkt, a * b);
		check_broadcast("collision mul", mul_pkt, 1'b1);
		check_value("collision idle", 64'd0, 64'(complete.valid));
		check_value("collision ready", 64'd1, 64'(mult_ready));
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		issue_valid = 1'b0;
		issue_sel   = fu_pkg::FU_INT;
		issue_pkt   = '0;
		lcg_state   = 32'd23736;
		rob_cnt     = 5'd0;
		tag_cnt     = 6'd1;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset();
		test_int_ops();
		test_branches();
		test_multiply();
		test_collision();
		$display("TESTS PASSED");
		$finish;
	end

endmodule
